// ==== cpu_core.f ====
design/isa_pkg.sv
design/pipe_pkg.sv
design/bypass_if.sv
design/pipe_reg.sv
design/fetch_stage.sv
design/decode_stage.sv
design/execute_stage.sv
design/memory_stage.sv
design/cpu_top.sv
sim/tb_clock_gen.sv
sim/cpu_properties.sv
sim/cpu_tb.sv

// ==== sim/cpu_tb.sv ====
/* Loads five programs in turn and compares every retirement with a sequential
   model. Programs stay well below 64 words, since the PC wraps into them again */
module cpu_tb;

    localparam int RESET_CYCLES = 4;
    localparam int LOAD_CYCLES  = 4;    // One four-phase transfer per word
    localparam int QUIET_CYCLES = 6;
    localparam int NUM_PROGS    = 5;
    localparam int RANDOM_COUNT = 40;

    typedef struct packed {
        isa_pkg::reg_idx_t rd;
        isa_pkg::word_t    data;
    } retire_t;

    logic               clk;
    logic               rst;
    logic               run;
    logic               load_req;
    isa_pkg::mem_addr_t load_addr;
    isa_pkg::instr_t    load_instr;
    logic               load_ack;
    logic               retire_valid;
    isa_pkg::reg_idx_t  retire_rd;
    isa_pkg::word_t     retire_data;

    isa_pkg::instr_t prog_mem [128];
    int              prog_start [NUM_PROGS];
    int              prog_len [NUM_PROGS];
    string           prog_name [NUM_PROGS];
    int              prog_fill = 0;
    retire_t         expected_q [$];
    string           cur_test = "init";
    int              cycles = 0;
    int              cycle_limit = 0;

    tb_clock_gen #(.PERIOD(100)) u_clock (.clk(clk));

    cpu_top DUT (
        .clk          (clk),
        .rst          (rst),
        .run          (run),
        .load_req     (load_req),
        .load_addr    (load_addr),
        .load_instr   (load_instr),
        .load_ack     (load_ack),
        .retire_valid (retire_valid),
        .retire_rd    (retire_rd),
        .retire_data  (retire_data)
    );

    // --------------------
    // Failure and compare
    // --------------------
    task automatic stop_with_failure();
        $display("RESULT: FAIL");
        $fatal(1);
    endtask

    task automatic check_rd(input string what, input isa_pkg::reg_idx_t want,
                            input isa_pkg::reg_idx_t got);
        if (got !== want) begin
            $display("** Error [%s] %s: expected %0d, actual %0d", cur_test, what, want, got);
            stop_with_failure();
        end
    endtask

    task automatic check_data(input string what, input isa_pkg::word_t want,
                              input isa_pkg::word_t got);
        if (got !== want) begin
            $display("** Error [%s] %s: expected %h, actual %h", cur_test, what, want, got);
            stop_with_failure();
        end
    endtask

    task automatic check_flag(input string what, input logic want, input logic got);
        if (got !== want) begin
            $display("** Error [%s] %s: expected %b, actual %b", cur_test, what, want, got);
            stop_with_failure();
        end
    endtask

    // --------------------
    // Programs and model
    // --------------------
    function automatic isa_pkg::instr_t encode(input isa_pkg::opcode_t op, input int rd,
                                               input int rn, input int rm, input int imm);
        isa_pkg::instr_t ins;
        ins.cond   = 4'h0;
        ins.opcode = op;
        ins.rn     = isa_pkg::reg_idx_t'(rn);
        ins.rm     = isa_pkg::reg_idx_t'(rm);
        ins.rd     = isa_pkg::reg_idx_t'(rd);
        ins.imm    = isa_pkg::imm_t'(imm);
        return ins;
    endfunction

    function automatic void add_instr(input isa_pkg::instr_t ins);
        prog_mem[prog_fill] = ins;
        prog_fill++;
    endfunction

    function automatic void close_program(input int idx, input string name);
        prog_name[idx] = name;
        prog_len[idx]  = prog_fill - prog_start[idx];
        if (idx + 1 < NUM_PROGS) begin
            prog_start[idx + 1] = prog_fill;
        end
    endfunction

    task automatic build_programs();
        isa_pkg::instr_t ins;
        prog_start[0] = 0;
        for (int k = 1; k <= 6; k++) begin     // Distinct targets with r0 left at zero
            add_instr(encode(isa_pkg::OP_ADDI, k, 0, 0, $urandom_range(0, 2047)));
        end
        close_program(0, "load_handshake");
        add_instr(encode(isa_pkg::OP_ADDI, 1, 0, 0, 'h1c3));
        add_instr(encode(isa_pkg::OP_ADDI, 2, 0, 0, 'h0a5));
        add_instr(encode(isa_pkg::OP_ADDI, 3, 0, 0, 'h7ff));
        add_instr(encode(isa_pkg::OP_ADDI, 4, 0, 0, 'h00f));
        add_instr(encode(isa_pkg::OP_NOP, 0, 0, 0, 0));
        add_instr(encode(isa_pkg::OP_NOP, 0, 0, 0, 0));
        add_instr(encode(isa_pkg::OP_ADD, 5, 1, 2, 0));
        add_instr(encode(isa_pkg::OP_SUB, 6, 3, 4, 0));
        add_instr(encode(isa_pkg::OP_AND, 7, 1, 3, 0));
        add_instr(encode(isa_pkg::OP_ORR, 8, 2, 4, 0));
        add_instr(encode(isa_pkg::OP_EOR, 9, 3, 1, 0));
        add_instr(encode(isa_pkg::OP_SUB, 10, 4, 3, 0));    // Negative result
        close_program(1, "independent_alu");
        add_instr(encode(isa_pkg::OP_ADDI, 1, 0, 0, 10));
        add_instr(encode(isa_pkg::OP_ADD, 2, 1, 1, 0));     // Distance one
        add_instr(encode(isa_pkg::OP_SUB, 3, 2, 1, 0));     // One and two
        add_instr(encode(isa_pkg::OP_EOR, 4, 3, 1, 0));     // r1 from the register file
        add_instr(encode(isa_pkg::OP_ORR, 5, 4, 2, 0));
        add_instr(encode(isa_pkg::OP_AND, 6, 5, 3, 0));
        add_instr(encode(isa_pkg::OP_ADDI, 6, 6, 0, 'h40));
        add_instr(encode(isa_pkg::OP_ADD, 7, 6, 5, 0));
        add_instr(encode(isa_pkg::OP_ADDI, 8, 0, 0, 1));
        add_instr(encode(isa_pkg::OP_ADDI, 8, 8, 0, 2));    // Same register twice
        add_instr(encode(isa_pkg::OP_ADD, 9, 8, 8, 0));
        close_program(2, "forwarding");
        add_instr(encode(isa_pkg::OP_ADDI, 1, 0, 0, 'h155));
        add_instr(encode(isa_pkg::OP_ADDI, 2, 0, 0, 3));
        add_instr(encode(isa_pkg::OP_STR, 0, 2, 1, 4));     // Store data forwarded
        add_instr(encode(isa_pkg::OP_LDR, 3, 2, 0, 4));
        add_instr(encode(isa_pkg::OP_ADD, 4, 3, 3, 0));     // Load-use on Rn and Rm
        add_instr(encode(isa_pkg::OP_STR, 0, 0, 4, 'h7fc)); // Wraps to word 60
        add_instr(encode(isa_pkg::OP_LDR, 5, 0, 0, 'h3c));
        add_instr(encode(isa_pkg::OP_STR, 0, 2, 5, 9));     // Load-use on store data
        add_instr(encode(isa_pkg::OP_LDR, 6, 0, 0, 12));
        add_instr(encode(isa_pkg::OP_ADDI, 7, 6, 0, 1));
        close_program(3, "memory_load_use");
        for (int k = 0; k < RANDOM_COUNT; k++) begin
            // Eight registers only for more hazards
            ins = encode(isa_pkg::opcode_t'($urandom_range(0, 8)), $urandom_range(0, 7),
                         $urandom_range(0, 7), $urandom_range(0, 7), $urandom_range(0, 2047));
            ins.cond = 4'($urandom_range(0, 15));
            add_instr(ins);
        end
        close_program(4, "random");
    endtask

    // Runs the program in order one instruction at a time
    function automatic void compute_expected(input int p);
        isa_pkg::word_t     regs [isa_pkg::NUM_REGS];
        isa_pkg::word_t     dmem [isa_pkg::DMEM_DEPTH];
        isa_pkg::instr_t    ins;
        isa_pkg::word_t     a;
        isa_pkg::word_t     b;
        isa_pkg::word_t     r;
        isa_pkg::mem_addr_t addr;
        logic               writes;
        foreach (regs[i]) regs[i] = '0;
        foreach (dmem[i]) dmem[i] = '0;
        for (int k = 0; k < prog_len[p]; k++) begin
            ins    = prog_mem[prog_start[p] + k];
            a      = regs[ins.rn];
            b      = regs[ins.rm];
            addr   = isa_pkg::mem_addr_t'(a + isa_pkg::word_t'(ins.imm));
            r      = '0;
            writes = 1'b1;
            case (ins.opcode)
                isa_pkg::OP_ADD:  r = a + b;
                isa_pkg::OP_SUB:  r = a - b;
                isa_pkg::OP_AND:  r = a & b;
                isa_pkg::OP_ORR:  r = a | b;
                isa_pkg::OP_EOR:  r = a ^ b;
                isa_pkg::OP_ADDI: r = a + isa_pkg::word_t'(ins.imm);
                isa_pkg::OP_LDR:  r = dmem[addr];
                isa_pkg::OP_STR: begin
                    dmem[addr] = b;
                    writes     = 1'b0;
                end
                default: writes = 1'b0;
            endcase
            if (writes) begin
                regs[ins.rd] = r;
                expected_q.push_back('{rd: ins.rd, data: r});
            end
        end
    endfunction

    // --------------------
    // Stimulus
    // --------------------
    // Callers are just past a rising edge
    task automatic apply_reset();
        rst      <= 1'b1;
        run      <= 1'b0;
        load_req <= 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        rst <= 1'b0;
    endtask

    task automatic load_word(input isa_pkg::mem_addr_t addr, input isa_pkg::instr_t ins);
        load_addr  <= addr;
        load_instr <= ins;
        load_req   <= 1'b1;
        @(posedge clk);
        while (!load_ack) @(posedge clk);
        load_req <= 1'b0;
        @(posedge clk);
        while (load_ack) @(posedge clk);
    endtask

    task automatic check_reset_state();
        cur_test = "reset";
        apply_reset();
        repeat (8) begin
            @(negedge clk);
            check_flag("retire_valid", 1'b0, retire_valid);
            check_flag("load_ack", 1'b0, load_ack);
        end
        @(posedge clk);
    endtask

    task automatic run_program(input int p);
        cur_test = prog_name[p];
        expected_q.delete();
        apply_reset();
        for (int k = 0; k < prog_len[p]; k++) begin
            load_word(isa_pkg::mem_addr_t'(k), prog_mem[prog_start[p] + k]);
        end
        compute_expected(p);
        run <= 1'b1;
        while (expected_q.size() != 0) @(posedge clk);
        repeat (QUIET_CYCLES) @(posedge clk);   // Catches extra retirements
    endtask

    // --------------------
    // Compare and timeout
    // --------------------
    always @(negedge clk) begin
        retire_t want;
        if (DUT.props.assert_failures != 0) begin
            $display("A port assertion failed during %s", cur_test);
            stop_with_failure();
        end
        if (!rst && retire_valid) begin
            if (expected_q.size() == 0) begin
                $display("Unexpected retirement of r%0d during %s", retire_rd, cur_test);
                stop_with_failure();
            end
            want = expected_q.pop_front();
            check_rd("rd", want.rd, retire_rd);
            check_data("data", want.data, retire_data);
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles > cycle_limit) begin
            $display("Timeout after %0d cycles during %s, the core stopped making progress",
                     cycles, cur_test);
            stop_with_failure();
        end
    end

    initial begin
        rst        <= 1'b1;
        run        <= 1'b0;
        load_req   <= 1'b0;
        load_addr  <= '0;
        load_instr <= '0;
        void'($urandom(60));
        build_programs();
        cycle_limit = RESET_CYCLES + 8 + 20;
        for (int p = 0; p < NUM_PROGS; p++) begin
            cycle_limit += 2 * prog_len[p] + LOAD_CYCLES * prog_len[p] + RESET_CYCLES + 20;
        end
        check_reset_state();
        for (int p = 0; p < NUM_PROGS; p++) begin
            run_program(p);
        end
        if (DUT.props.assert_failures == 0) begin
            $display("RESULT: PASS");
            $finish;
        end else begin
            $display("Port assertions failed during the run");
            stop_with_failure();
        end
    end

endmodule

// ==== sim/cpu_properties.sv ====
/* Port-level checks, bound into cpu_top. run_seen assumes that run stays
   high once the host has raised it */
module cpu_properties (
    input logic clk,
    input logic rst,
    input logic run,
    input logic load_req,
    input logic load_ack,
    input logic retire_valid
);

    int   assert_failures = 0;
    logic run_seen;     // Run was high at some edge since reset

    always_ff @(posedge clk) begin
        if (rst) begin
            run_seen <= 1'b0;
        end else if (run) begin
            run_seen <= 1'b1;
        end
    end

    // --------------------
    // Load handshake
    // --------------------
    ack_rise: assert property (@(posedge clk) disable iff (rst)
        $rose(load_ack) |-> $past(load_req))
        else begin
            $error("load_ack rose without load_req high");
            assert_failures++;
        end

    ack_fall: assert property (@(posedge clk) disable iff (rst)
        $fell(load_ack) |-> !$past(load_req))
        else begin
            $error("load_ack fell while load_req was still high");
            assert_failures++;
        end

    // --------------------
    // Retire port
    // --------------------
    quiet_after_reset: assert property (@(posedge clk)
        rst |=> !retire_valid)
        else begin
            $error("retire_valid high in the cycle after reset");
            assert_failures++;
        end

    quiet_before_run: assert property (@(posedge clk) disable iff (rst)
        !(run_seen || run) |-> !retire_valid)
        else begin
            $error("retire_valid high before run was raised");
            assert_failures++;
        end

endmodule

bind cpu_top cpu_properties props (
    .clk          (clk),
    .rst          (rst),
    .run          (run),
    .load_req     (load_req),
    .load_ack     (load_ack),
    .retire_valid (retire_valid)
);

// ==== sim/tb_clock_gen.sv ====
/* Free-running testbench clock, starts low */
module tb_clock_gen #(
    parameter int PERIOD = 100
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

endmodule

// ==== design/cpu_top.sv ====
/* Load the program with run low, then raise run and keep it high. The retire
   port shows register writes only, in program order */
module cpu_top (
    input  logic               clk,
    input  logic               rst,
    input  logic               run,
    input  logic               load_req,
    input  isa_pkg::mem_addr_t load_addr,
    input  isa_pkg::instr_t    load_instr,
    output logic               load_ack,
    output logic               retire_valid,
    output isa_pkg::reg_idx_t  retire_rd,
    output isa_pkg::word_t     retire_data
);

    pipe_pkg::if_id_t  fetch_d;
    pipe_pkg::if_id_t  if_id_q;
    pipe_pkg::id_ex_t  decode_d;
    pipe_pkg::id_ex_t  id_ex_q;
    pipe_pkg::ex_mem_t exec_d;
    pipe_pkg::ex_mem_t ex_mem_q;
    pipe_pkg::mem_wb_t mem_d;
    pipe_pkg::mem_wb_t mem_wb_q;
    logic              stall;
    logic              wb_write;

    bypass_if byp ();

    // --------------------
    // Stages and registers
    // --------------------
    fetch_stage u_fetch (
        .clk        (clk),
        .rst        (rst),
        .run        (run),
        .stall      (stall),
        .load_req   (load_req),
        .load_addr  (load_addr),
        .load_instr (load_instr),
        .load_ack   (load_ack),
        .fetched    (fetch_d)
    );

    pipe_reg #(.payload_t(pipe_pkg::if_id_t)) if_id_r (
        .clk(clk), .rst(rst), .hold(stall), .bubble(1'b0), .d(fetch_d), .q(if_id_q)
    );

    decode_stage u_decode (
        .clk         (clk),
        .rst         (rst),
        .fetched     (if_id_q),
        .ex_rd       (id_ex_q.rd),
        .ex_mem_read (id_ex_q.valid && id_ex_q.mem_read),
        .wb          (byp.writeback),
        .decoded     (decode_d),
        .stall       (stall)
    );

    // Stalled instruction stays in IF/ID while a bubble goes on
    pipe_reg #(.payload_t(pipe_pkg::id_ex_t)) id_ex_r (
        .clk(clk), .rst(rst), .hold(1'b0), .bubble(stall), .d(decode_d), .q(id_ex_q)
    );

    execute_stage u_execute (
        .issued   (id_ex_q),
        .fwd      (byp.forward),
        .executed (exec_d)
    );

    pipe_reg #(.payload_t(pipe_pkg::ex_mem_t)) ex_mem_r (
        .clk(clk), .rst(rst), .hold(1'b0), .bubble(1'b0), .d(exec_d), .q(ex_mem_q)
    );

    memory_stage u_memory (
        .clk         (clk),
        .rst         (rst),
        .accessed_in (ex_mem_q),
        .result      (mem_d)
    );

    pipe_reg #(.payload_t(pipe_pkg::mem_wb_t)) mem_wb_r (
        .clk(clk), .rst(rst), .hold(1'b0), .bubble(1'b0), .d(mem_d), .q(mem_wb_q)
    );

    // --------------------
    // Writeback and bypass
    // --------------------
    assign wb_write = mem_wb_q.valid && mem_wb_q.reg_write;

    assign byp.ex_mem_write = ex_mem_q.valid && ex_mem_q.reg_write;
    assign byp.ex_mem_rd    = ex_mem_q.rd;
    assign byp.ex_mem_data  = ex_mem_q.alu_result;
    assign byp.mem_wb_write = wb_write;
    assign byp.mem_wb_rd    = mem_wb_q.rd;
    assign byp.mem_wb_data  = mem_wb_q.result;

    assign retire_valid = wb_write;     // Same cycle as the register file write
    assign retire_rd    = mem_wb_q.rd;
    assign retire_data  = mem_wb_q.result;

endmodule

// ==== design/memory_stage.sv ====
/* Data memory is cleared on reset. Only the low address bits are used, so
   accesses past the end wrap */
module memory_stage (
    input  logic              clk,
    input  logic              rst,
    input  pipe_pkg::ex_mem_t accessed_in,
    output pipe_pkg::mem_wb_t result
);

    isa_pkg::word_t     dmem [isa_pkg::DMEM_DEPTH];
    isa_pkg::mem_addr_t addr;
    isa_pkg::word_t     load_data;

    assign addr = accessed_in.alu_result[$bits(isa_pkg::mem_addr_t)-1:0];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < isa_pkg::DMEM_DEPTH; i++) begin
                dmem[i] <= '0;
            end
        end else if (accessed_in.valid && accessed_in.mem_write) begin
            dmem[addr] <= accessed_in.store_data;
        end
    end

    assign load_data = dmem[addr];  // Asynchronous read

    assign result = '{valid:     accessed_in.valid,
                      result:    accessed_in.mem_read ? load_data : accessed_in.alu_result,
                      rd:        accessed_in.rd,
                      reg_write: accessed_in.reg_write};

endmodule

// ==== design/execute_stage.sv ====
/* Purely combinational. EX/MEM forwarding assumes no load sits there while a
   dependent instruction executes, which the decode stall guarantees */
module execute_stage (
    input  pipe_pkg::id_ex_t  issued,
    bypass_if.forward         fwd,
    output pipe_pkg::ex_mem_t executed
);

    pipe_pkg::fwd_sel_t sel_a;
    pipe_pkg::fwd_sel_t sel_b;
    isa_pkg::word_t     op_a;
    isa_pkg::word_t     rm_fwd;
    isa_pkg::word_t     op_b;
    isa_pkg::word_t     alu_res;

    // Younger result wins
    function automatic pipe_pkg::fwd_sel_t pick_src(
        input isa_pkg::reg_idx_t src,
        input logic              em_write,
        input isa_pkg::reg_idx_t em_rd,
        input logic              mw_write,
        input isa_pkg::reg_idx_t mw_rd
    );
        if (em_write && em_rd == src) return pipe_pkg::FWD_EX_MEM;
        if (mw_write && mw_rd == src) return pipe_pkg::FWD_MEM_WB;
        return pipe_pkg::FWD_REGFILE;
    endfunction

    function automatic isa_pkg::word_t pick_val(
        input pipe_pkg::fwd_sel_t sel,
        input isa_pkg::word_t     rf_val,
        input isa_pkg::word_t     em_val,
        input isa_pkg::word_t     mw_val
    );
        case (sel)
            pipe_pkg::FWD_EX_MEM: return em_val;
            pipe_pkg::FWD_MEM_WB: return mw_val;
            default:              return rf_val;
        endcase
    endfunction

    // --------------------
    // Operand forwarding
    // --------------------
    assign sel_a = pick_src(issued.rn, fwd.ex_mem_write, fwd.ex_mem_rd,
                            fwd.mem_wb_write, fwd.mem_wb_rd);
    assign sel_b = pick_src(issued.rm, fwd.ex_mem_write, fwd.ex_mem_rd,
                            fwd.mem_wb_write, fwd.mem_wb_rd);

    assign op_a   = pick_val(sel_a, issued.rn_val, fwd.ex_mem_data, fwd.mem_wb_data);
    assign rm_fwd = pick_val(sel_b, issued.rm_val, fwd.ex_mem_data, fwd.mem_wb_data);
    assign op_b   = issued.alu_src_imm ? issued.imm : rm_fwd;

    // --------------------
    // ALU
    // --------------------
    always_comb begin
        case (issued.alu_op)
            pipe_pkg::ALU_SUB: alu_res = op_a - op_b;
            pipe_pkg::ALU_AND: alu_res = op_a & op_b;
            pipe_pkg::ALU_OR:  alu_res = op_a | op_b;
            pipe_pkg::ALU_XOR: alu_res = op_a ^ op_b;
            default:           alu_res = op_a + op_b;
        endcase
    end

    assign executed = '{valid:      issued.valid,
                        alu_result: alu_res,
                        store_data: rm_fwd,       // STR stores Rm
                        rd:         issued.rd,
                        reg_write:  issued.reg_write,
                        mem_read:   issued.mem_read,
                        mem_write:  issued.mem_write};

endmodule

// ==== design/decode_stage.sv ====
/* Register file resets to zero and is write-first, so a read of the register
   being written back returns the new value. Stall covers load-use only */
module decode_stage (
    input  logic              clk,
    input  logic              rst,
    input  pipe_pkg::if_id_t  fetched,
    input  isa_pkg::reg_idx_t ex_rd,
    input  logic              ex_mem_read,
    bypass_if.writeback       wb,
    output pipe_pkg::id_ex_t  decoded,
    output logic              stall
);

    isa_pkg::instr_t   instr;
    isa_pkg::word_t    regs [isa_pkg::NUM_REGS];
    isa_pkg::word_t    rn_val;
    isa_pkg::word_t    rm_val;
    pipe_pkg::alu_op_t alu_op;
    logic              is_rr;     // Register-register ALU op
    logic              is_mem;
    logic              reads_rn;
    logic              reads_rm;

    assign instr = fetched.instr;

    // --------------------
    // Register file
    // --------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < isa_pkg::NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wb.mem_wb_write) begin
            regs[wb.mem_wb_rd] <= wb.mem_wb_data;
        end
    end

    assign rn_val = (wb.mem_wb_write && wb.mem_wb_rd == instr.rn) ? wb.mem_wb_data
                                                                  : regs[instr.rn];
    assign rm_val = (wb.mem_wb_write && wb.mem_wb_rd == instr.rm) ? wb.mem_wb_data
                                                                  : regs[instr.rm];

    // --------------------
    // Control decode
    // --------------------
    assign is_rr  = instr.opcode inside {isa_pkg::OP_ADD, isa_pkg::OP_SUB, isa_pkg::OP_AND,
                                         isa_pkg::OP_ORR, isa_pkg::OP_EOR};
    assign is_mem = instr.opcode inside {isa_pkg::OP_LDR, isa_pkg::OP_STR};

    assign reads_rn = fetched.valid && (is_rr || is_mem || instr.opcode == isa_pkg::OP_ADDI);
    assign reads_rm = fetched.valid && (is_rr || instr.opcode == isa_pkg::OP_STR);

    always_comb begin
        case (instr.opcode)
            isa_pkg::OP_SUB: alu_op = pipe_pkg::ALU_SUB;
            isa_pkg::OP_AND: alu_op = pipe_pkg::ALU_AND;
            isa_pkg::OP_ORR: alu_op = pipe_pkg::ALU_OR;
            isa_pkg::OP_EOR: alu_op = pipe_pkg::ALU_XOR;
            default:         alu_op = pipe_pkg::ALU_ADD; // Also the LDR/STR address add
        endcase
    end

    always_comb begin
        decoded.valid       = fetched.valid;
        decoded.rn          = instr.rn;
        decoded.rm          = instr.rm;
        decoded.rn_val      = rn_val;
        decoded.rm_val      = rm_val;
        decoded.imm         = isa_pkg::word_t'(instr.imm);
        decoded.rd          = instr.rd;
        decoded.alu_op      = alu_op;
        decoded.alu_src_imm = !is_rr;
        decoded.reg_write   = fetched.valid && (is_rr || instr.opcode == isa_pkg::OP_ADDI
                                                      || instr.opcode == isa_pkg::OP_LDR);
        decoded.mem_read    = fetched.valid && instr.opcode == isa_pkg::OP_LDR;
        decoded.mem_write   = fetched.valid && instr.opcode == isa_pkg::OP_STR;
    end

    // Load in execute whose result this instruction needs next cycle
    assign stall = ex_mem_read && ((reads_rn && ex_rd == instr.rn) ||
                                   (reads_rm && ex_rd == instr.rm));

endmodule

// ==== design/fetch_stage.sv ====
/* Program is loaded over a four-phase req/ack port while run is low.
   PC stays at zero until run rises and then wraps after the last word */
module fetch_stage (
    input  logic               clk,
    input  logic               rst,
    input  logic               run,
    input  logic               stall,
    input  logic               load_req,
    input  isa_pkg::mem_addr_t load_addr,
    input  isa_pkg::instr_t    load_instr,
    output logic               load_ack,
    output pipe_pkg::if_id_t   fetched
);

    isa_pkg::instr_t    imem [isa_pkg::IMEM_DEPTH];
    isa_pkg::mem_addr_t pc;
    logic               load_wr;

    // --------------------
    // Load handshake
    // --------------------
    assign load_wr = load_req && !load_ack;  // First cycle of a request

    // Ack follows req by one cycle in both directions
    always_ff @(posedge clk) begin
        if (rst) begin
            load_ack <= 1'b0;
        end else begin
            load_ack <= load_req;
        end
    end

    // Cleared on reset so words past the program read as NOP
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < isa_pkg::IMEM_DEPTH; i++) begin
                imem[i] <= '0;
            end
        end else if (load_wr) begin
            imem[load_addr] <= load_instr;
        end
    end

    // --------------------
    // Program counter
    // --------------------
    always_ff @(posedge clk) begin
        if (rst || !run) begin
            pc <= '0;
        end else if (!stall) begin
            pc <= pc + 1'b1;    // Wraps at the memory size
        end
    end

    // Invalid while halted, so decode sees bubbles
    assign fetched = '{valid: run, instr: imem[pc]};

endmodule

// ==== design/pipe_reg.sv ====
/* Hold wins over bubble. A bubble is the all-zero payload */
module pipe_reg #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     rst,
    input  logic     hold,
    input  logic     bubble,
    input  payload_t d,
    output payload_t q
);

    always_ff @(posedge clk) begin
        if (rst) begin
            q <= '0;
        end else if (!hold) begin
            if (bubble) begin
                q <= '0;    // Kill the slot
            end else begin
                q <= d;
            end
        end
    end

endmodule

// ==== design/bypass_if.sv ====
/* Write results of the EX/MEM and MEM/WB registers. The MEM/WB half is also
   the register file write port */
interface bypass_if;

    logic              ex_mem_write;
    isa_pkg::reg_idx_t ex_mem_rd;
    isa_pkg::word_t    ex_mem_data;  // ALU result only
    logic              mem_wb_write;
    isa_pkg::reg_idx_t mem_wb_rd;
    isa_pkg::word_t    mem_wb_data;

    modport source (
        output ex_mem_write, ex_mem_rd, ex_mem_data,
        output mem_wb_write, mem_wb_rd, mem_wb_data
    );

    modport forward (
        input ex_mem_write, ex_mem_rd, ex_mem_data,
        input mem_wb_write, mem_wb_rd, mem_wb_data
    );

    modport writeback (
        input mem_wb_write, mem_wb_rd, mem_wb_data
    );

endinterface

// ==== design/pipe_pkg.sv ====
/* Payloads held by the pipeline registers. An all-zero payload is a bubble,
   so every control bit must be active high */
package pipe_pkg;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR
    } alu_op_t;

    // Operand source picked in execute
    typedef enum logic [1:0] {
        FWD_REGFILE,
        FWD_EX_MEM,
        FWD_MEM_WB
    } fwd_sel_t;

    typedef struct packed {
        logic            valid;
        isa_pkg::instr_t instr;
    } if_id_t;

    typedef struct packed {
        logic              valid;
        isa_pkg::reg_idx_t rn;
        isa_pkg::reg_idx_t rm;
        isa_pkg::word_t    rn_val;
        isa_pkg::word_t    rm_val;
        isa_pkg::word_t    imm;         // Already zero-extended
        isa_pkg::reg_idx_t rd;
        alu_op_t           alu_op;
        logic              alu_src_imm; // Second operand is imm, not Rm
        logic              reg_write;
        logic              mem_read;
        logic              mem_write;
    } id_ex_t;

    typedef struct packed {
        logic              valid;
        isa_pkg::word_t    alu_result;  // Also the data address
        isa_pkg::word_t    store_data;
        isa_pkg::reg_idx_t rd;
        logic              reg_write;
        logic              mem_read;
        logic              mem_write;
    } ex_mem_t;

    typedef struct packed {
        logic              valid;
        isa_pkg::word_t    result;
        isa_pkg::reg_idx_t rd;
        logic              reg_write;
    } mem_wb_t;

endpackage

// ==== design/isa_pkg.sv ====
/* Instruction encoding of the cut-down core. The cond field is carried in the
   word but never evaluated. Both memories are word addressed and wrap at 64 */
package isa_pkg;

    // --------------------
    // Sizes
    // --------------------
    localparam int IMEM_DEPTH = 64;
    localparam int DMEM_DEPTH = 64;
    localparam int NUM_REGS   = 16;

    // --------------------
    // Basic types
    // --------------------
    typedef logic [31:0]                    word_t;
    typedef logic [$clog2(NUM_REGS)-1:0]    reg_idx_t;
    typedef logic [10:0]                    imm_t;      // Zero-extended on use
    typedef logic [$clog2(IMEM_DEPTH)-1:0]  mem_addr_t; // Shared by both memories

    // Codes not listed here decode as NOP
    typedef enum logic [4:0] {
        OP_NOP  = 5'd0,
        OP_ADD  = 5'd1,
        OP_SUB  = 5'd2,
        OP_AND  = 5'd3,
        OP_ORR  = 5'd4,
        OP_EOR  = 5'd5,
        OP_ADDI = 5'd6,
        OP_LDR  = 5'd7,
        OP_STR  = 5'd8
    } opcode_t;

    // Field order gives bits 31:28, 27:23, 22:19, 18:15, 14:11, 10:0
    typedef struct packed {
        logic [3:0] cond;
        opcode_t    opcode;
        reg_idx_t   rn;
        reg_idx_t   rm;
        reg_idx_t   rd;
        imm_t       imm;
    } instr_t;

endpackage
